// ==== design/gpio_bank.sv ====
`default_nettype none

`include "periph_params.svh"

module gpio_bank #(
	parameter type pins_t = logic [7:0]
) (
	input  wire                   wb_clk_i,
	input  wire                   rst_n_i,
	input  wire                   stb_i,
	input  wire                   wb_cyc_i,
	input  wire                   wb_we_i,
	input  wire wb_pkg::reg_idx_t reg_i,
	input  wire wb_pkg::wb_data_t wdat_i,
	input  wire pins_t            gpio_i,
	output logic                  ack_o,
	output wb_pkg::wb_data_t      rdat_o,
	output pins_t                 gpio_o,
	output pins_t                 gpio_oe_o,
	output logic                  irq_o
);
	import wb_pkg::*;

	// Pin count of this bank
	localparam int W = $bits(pins_t);

	// Bus side
	logic     access;
	logic     wr;
	wb_data_t rd_val;

	// Software registers
	pins_t out_q;
	pins_t dir_q;
	pins_t ien_q;
	pins_t stat_q;

	// Input path
	pins_t sync1_q;
	pins_t sync2_q;
	pins_t prev_q;
	pins_t rise;
	pins_t stat_clr;

	////////////////////////////////////////////////////////////
	// Bus handshake
	////////////////////////////////////////////////////////////

	// New access only while ack is low
	assign access = stb_i & wb_cyc_i & ~ack_o;
	assign wr     = access & wb_we_i;

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= access;
		end
	end

	// Undefined offsets read as zero
	always_comb begin
		rd_val = '0;
		case (reg_i)
			`GPIO_REG_OUT:  rd_val[W-1:0] = out_q;
			`GPIO_REG_DIR:  rd_val[W-1:0] = dir_q;
			`GPIO_REG_IN:   rd_val[W-1:0] = sync2_q;
			`GPIO_REG_IEN:  rd_val[W-1:0] = ien_q;
			`GPIO_REG_STAT: rd_val[W-1:0] = stat_q;
			default:        rd_val = '0;
		endcase
	end

	// Data lands together with ack
	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			rdat_o <= rd_val;
		end
	end

	////////////////////////////////////////////////////////////
	// Output, direction and enable registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			out_q <= '0;
			dir_q <= '0;
			ien_q <= '0;
		end else if (wr) begin
			case (reg_i)
				`GPIO_REG_OUT: out_q <= wdat_i[W-1:0];
				`GPIO_REG_DIR: dir_q <= wdat_i[W-1:0];
				`GPIO_REG_IEN: ien_q <= wdat_i[W-1:0];
				// IN is read only, STAT handled below
				default: ;
			endcase
		end
	end

	assign gpio_o    = out_q;
	assign gpio_oe_o = dir_q;

	////////////////////////////////////////////////////////////
	// Input sync and edge status
	////////////////////////////////////////////////////////////

	// Two flop synchronizer then one flop for edge detect
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
		end else begin
			sync1_q <= gpio_i;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
		end
	end

	assign rise = sync2_q & ~prev_q;

	// Write one to clear
	always_comb begin
		stat_clr = '0;
		if (wr && (reg_i == `GPIO_REG_STAT)) begin
			stat_clr = wdat_i[W-1:0];
		end
	end

	// Fresh edge wins over a clear in the same cycle
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			stat_q <= '0;
		end else begin
			stat_q <= (stat_q & ~stat_clr) | (rise & ien_q);
		end
	end

	// Level request while any status bit is up
	assign irq_o = |stat_q;

endmodule

`default_nettype wire

// ==== design/irq_ctrl.sv ====
`default_nettype none

`include "periph_params.svh"

module irq_ctrl (
	input  wire                      wb_clk_i,
	input  wire                      rst_n_i,
	input  wire                      stb_i,
	input  wire                      wb_cyc_i,
	input  wire                      wb_we_i,
	input  wire wb_pkg::reg_idx_t    reg_i,
	input  wire wb_pkg::wb_data_t    wdat_i,
	input  wire periph_pkg::irq_vec_t src_i,
	output logic                     ack_o,
	output wb_pkg::wb_data_t         rdat_o,
	output logic                     irq_o
);
	import wb_pkg::*;
	import periph_pkg::*;

	logic     access;
	logic     wr;
	wb_data_t rd_val;

	// Enabled sources
	irq_vec_t mask_q;
	// Raw sources that pass the mask
	irq_vec_t pend;

	////////////////////////////////////////////////////////////
	// Bus handshake
	////////////////////////////////////////////////////////////

	assign access = stb_i & wb_cyc_i & ~ack_o;
	assign wr     = access & wb_we_i;

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= access;
		end
	end

	always_comb begin
		case (reg_i)
			`IRQ_REG_RAW:  rd_val = src_i;
			`IRQ_REG_MASK: rd_val = mask_q;
			`IRQ_REG_PEND: rd_val = pend;
			default:       rd_val = '0;
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			rdat_o <= rd_val;
		end
	end

	////////////////////////////////////////////////////////////
	// Mask and request
	////////////////////////////////////////////////////////////

	// RAW and PEND ignore writes
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			mask_q <= '0;
		end else if (wr && (reg_i == `IRQ_REG_MASK)) begin
			mask_q <= wdat_i;
		end
	end

	// Sources are levels, cleared at their bank
	assign pend  = src_i & mask_q;
	assign irq_o = |pend;

endmodule

`default_nettype wire

// ==== design/periph_params.svh ====
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// Bus word and address widths
`define WB_DW 32
`define WB_AW 32

// Slave field of the byte address
`define SLV_SEL_MSB 7
`define SLV_SEL_LSB 5

// Register field of the byte address, word aligned
`define REG_SEL_MSB 4
`define REG_SEL_LSB 2

// Slave indices, all others unmapped
`define SLV_GPIO0 3'd0
`define SLV_GPIO1 3'd1
`define SLV_IRQ   3'd2

// GPIO register offsets
`define GPIO_REG_OUT  3'd0
`define GPIO_REG_DIR  3'd1
`define GPIO_REG_IN   3'd2
`define GPIO_REG_IEN  3'd3
`define GPIO_REG_STAT 3'd4

// Interrupt controller register offsets
`define IRQ_REG_RAW  3'd0
`define IRQ_REG_MASK 3'd1
`define IRQ_REG_PEND 3'd2

// Source slots after UART and SPI sources
`define IRQ_BIT_GPIO0 6
`define IRQ_BIT_GPIO1 7

// Pin counts per bank
`define GPIO0_W 8
`define GPIO1_W 4

`endif

// ==== design/periph_pkg.sv ====
`default_nettype none

`include "periph_params.svh"

////////////////////////////////////////////////////////////
// Peripheral types
////////////////////////////////////////////////////////////

package periph_pkg;

	// Bank 0 pins
	typedef logic [`GPIO0_W-1:0] gpio0_pins_t;

	// Bank 1 pins, the narrow bank
	typedef logic [`GPIO1_W-1:0] gpio1_pins_t;

	// Slave index taken from the address
	typedef logic [`SLV_SEL_MSB-`SLV_SEL_LSB:0] slv_sel_t;

	// One bit per interrupt source
	// Same width as the bus so RAW and PEND read back whole
	typedef logic [`WB_DW-1:0] irq_vec_t;

endpackage

`default_nettype wire

// ==== design/periph_top.sv ====
`default_nettype none

`include "periph_params.svh"

module periph_top (
	input  wire                         wb_clk_i,
	input  wire                         rst_n_i,
	input  wire                         wb_cyc_i,
	input  wire                         wb_stb_i,
	input  wire                         wb_we_i,
	input  wire wb_pkg::wb_addr_t       wb_adr_i,
	input  wire wb_pkg::wb_sel_t        wb_sel_i,
	input  wire wb_pkg::wb_data_t       wb_dat_i,
	input  wire periph_pkg::gpio0_pins_t gpio0_i,
	input  wire periph_pkg::gpio1_pins_t gpio1_i,
	output logic                        wb_ack_o,
	output logic                        wb_err_o,
	output wb_pkg::wb_data_t            wb_dat_o,
	output periph_pkg::gpio0_pins_t     gpio0_o,
	output periph_pkg::gpio0_pins_t     gpio0_oe_o,
	output periph_pkg::gpio1_pins_t     gpio1_o,
	output periph_pkg::gpio1_pins_t     gpio1_oe_o,
	output logic                        irq_o
);
	import wb_pkg::*;
	import periph_pkg::*;

	// Strobes from the decoder
	logic gpio0_stb;
	logic gpio1_stb;
	logic irq_stb;

	// Slave answers
	logic     gpio0_ack;
	logic     gpio1_ack;
	logic     irq_ack;
	wb_data_t gpio0_dat;
	wb_data_t gpio1_dat;
	wb_data_t irq_dat;

	// Register field shared by all slaves
	reg_idx_t reg_idx;

	// Bank requests and the assembled source vector
	logic     gpio0_irq;
	logic     gpio1_irq;
	irq_vec_t irq_src;

	assign reg_idx = wb_adr_i[`REG_SEL_MSB:`REG_SEL_LSB];

	////////////////////////////////////////////////////////////
	// Address decoder
	////////////////////////////////////////////////////////////

	wb_decoder u_decoder (
		.wb_clk_i    (wb_clk_i),
		.rst_n_i     (rst_n_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_adr_i    (wb_adr_i),
		.gpio0_ack_i (gpio0_ack),
		.gpio1_ack_i (gpio1_ack),
		.irq_ack_i   (irq_ack),
		.gpio0_dat_i (gpio0_dat),
		.gpio1_dat_i (gpio1_dat),
		.irq_dat_i   (irq_dat),
		.gpio0_stb_o (gpio0_stb),
		.gpio1_stb_o (gpio1_stb),
		.irq_stb_o   (irq_stb),
		.wb_ack_o    (wb_ack_o),
		.wb_err_o    (wb_err_o),
		.wb_dat_o    (wb_dat_o)
	);

	////////////////////////////////////////////////////////////
	// GPIO banks
	////////////////////////////////////////////////////////////

	gpio_bank #(
		.pins_t (gpio0_pins_t)
	) u_gpio0 (
		.wb_clk_i  (wb_clk_i),
		.rst_n_i   (rst_n_i),
		.stb_i     (gpio0_stb),
		.wb_cyc_i  (wb_cyc_i),
		.wb_we_i   (wb_we_i),
		.reg_i     (reg_idx),
		.wdat_i    (wb_dat_i),
		.gpio_i    (gpio0_i),
		.ack_o     (gpio0_ack),
		.rdat_o    (gpio0_dat),
		.gpio_o    (gpio0_o),
		.gpio_oe_o (gpio0_oe_o),
		.irq_o     (gpio0_irq)
	);

	// Narrow bank built from the same core
	gpio_bank #(
		.pins_t (gpio1_pins_t)
	) u_gpio1 (
		.wb_clk_i  (wb_clk_i),
		.rst_n_i   (rst_n_i),
		.stb_i     (gpio1_stb),
		.wb_cyc_i  (wb_cyc_i),
		.wb_we_i   (wb_we_i),
		.reg_i     (reg_idx),
		.wdat_i    (wb_dat_i),
		.gpio_i    (gpio1_i),
		.ack_o     (gpio1_ack),
		.rdat_o    (gpio1_dat),
		.gpio_o    (gpio1_o),
		.gpio_oe_o (gpio1_oe_o),
		.irq_o     (gpio1_irq)
	);

	////////////////////////////////////////////////////////////
	// Interrupt controller
	////////////////////////////////////////////////////////////

	// Former UART and SPI slots stay low
	always_comb begin
		irq_src                 = '0;
		irq_src[`IRQ_BIT_GPIO0] = gpio0_irq;
		irq_src[`IRQ_BIT_GPIO1] = gpio1_irq;
	end

	irq_ctrl u_irq (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.stb_i    (irq_stb),
		.wb_cyc_i (wb_cyc_i),
		.wb_we_i  (wb_we_i),
		.reg_i    (reg_idx),
		.wdat_i   (wb_dat_i),
		.src_i    (irq_src),
		.ack_o    (irq_ack),
		.rdat_o   (irq_dat),
		.irq_o    (irq_o)
	);

endmodule

`default_nettype wire

// ==== design/wb_decoder.sv ====
`default_nettype none

`include "periph_params.svh"

module wb_decoder (
	input  wire                   wb_clk_i,
	input  wire                   rst_n_i,
	input  wire                   wb_cyc_i,
	input  wire                   wb_stb_i,
	input  wire wb_pkg::wb_addr_t wb_adr_i,
	input  wire                   gpio0_ack_i,
	input  wire                   gpio1_ack_i,
	input  wire                   irq_ack_i,
	input  wire wb_pkg::wb_data_t gpio0_dat_i,
	input  wire wb_pkg::wb_data_t gpio1_dat_i,
	input  wire wb_pkg::wb_data_t irq_dat_i,
	output logic                  gpio0_stb_o,
	output logic                  gpio1_stb_o,
	output logic                  irq_stb_o,
	output logic                  wb_ack_o,
	output logic                  wb_err_o,
	output wb_pkg::wb_data_t      wb_dat_o
);
	import wb_pkg::*;
	import periph_pkg::*;

	// Decoded slave field
	slv_sel_t slv;
	// Active request from the master
	logic     req;
	// No slave behind this index
	logic     unmapped;
	// Mux result before it leaves the block
	wb_data_t dat_mux;

	////////////////////////////////////////////////////////////
	// Slave select
	////////////////////////////////////////////////////////////

	assign slv = wb_adr_i[`SLV_SEL_MSB:`SLV_SEL_LSB];
	assign req = wb_cyc_i & wb_stb_i;

	// At most one strobe, none for unmapped space
	assign gpio0_stb_o = wb_stb_i & (slv == `SLV_GPIO0);
	assign gpio1_stb_o = wb_stb_i & (slv == `SLV_GPIO1);
	assign irq_stb_o   = wb_stb_i & (slv == `SLV_IRQ);

	////////////////////////////////////////////////////////////
	// Return path
	////////////////////////////////////////////////////////////

	// Master holds the address until ack, so the same field
	// steers data and ack back
	always_comb begin
		unmapped = 1'b0;
		dat_mux  = '0;
		wb_ack_o = 1'b0;
		case (slv)
			`SLV_GPIO0: begin
				dat_mux  = gpio0_dat_i;
				wb_ack_o = gpio0_ack_i;
			end
			`SLV_GPIO1: begin
				dat_mux  = gpio1_dat_i;
				wb_ack_o = gpio1_ack_i;
			end
			`SLV_IRQ: begin
				dat_mux  = irq_dat_i;
				wb_ack_o = irq_ack_i;
			end
			// Zero data on error cycles
			default: unmapped = 1'b1;
		endcase
	end

	assign wb_dat_o = dat_mux;

	// Error answer with the same one cycle latency as a slave
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			wb_err_o <= 1'b0;
		end else begin
			wb_err_o <= req & unmapped & ~wb_err_o;
		end
	end

endmodule

`default_nettype wire

// ==== design/wb_pkg.sv ====
`default_nettype none

`include "periph_params.svh"

////////////////////////////////////////////////////////////
// Wishbone bus types
////////////////////////////////////////////////////////////

package wb_pkg;

	// Byte address as driven by the master
	typedef logic [`WB_AW-1:0] wb_addr_t;

	// One bus word
	typedef logic [`WB_DW-1:0] wb_data_t;

	// One enable per byte lane
	// Slaves only ever see full words
	typedef logic [`WB_DW/8-1:0] wb_sel_t;

	// Word index inside one slave
	typedef logic [`REG_SEL_MSB-`REG_SEL_LSB:0] reg_idx_t;

endpackage

`default_nettype wire

// ==== periph_hub.f ====
+incdir+design
design/wb_pkg.sv
design/periph_pkg.sv
design/wb_decoder.sv
design/gpio_bank.sv
design/irq_ctrl.sv
design/periph_top.sv
testbench/periph_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module periph_tb -f periph_hub.f \
	-o periph_sim > build.log 2>&1 &&
	./obj_dir/periph_sim > sim.log 2>&1 ||
	{ echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log &&
	echo "Simulation passed" ||
	{ echo "Simulation failed, see sim.log"; exit 1; }

// ==== testbench/periph_cases.txt ====
// Columns: op address data expected, all hex
// Ops: 1 wr, 2 wr random, 3 rd, 4 rd vs random&mask, 5 pins in, 6 wait, 7 irq, 8/9 pins, a/b err rd/wr
3 00 0 0
3 04 0 0
3 08 0 0
3 0C 0 0
3 10 0 0
3 20 0 0
3 24 0 0
3 28 0 0
3 2C 0 0
3 30 0 0
3 40 0 0
3 44 0 0
3 48 0 0
8 0 0 0
8 1 0 0
8 2 0 0
8 3 0 0
7 0 0 0
2 00 0 0
9 0 0 FF
4 00 0 FF
2 04 0 0
9 1 0 FF
4 04 0 FF
2 20 0 0
9 2 0 F
4 20 0 F
2 24 0 0
9 3 0 F
4 24 0 F
5 1 A 0
6 0 3 0
3 28 0 A
1 28 5 0
3 28 0 A
3 30 0 0
7 0 0 0
1 2C 1 0
5 1 B 0
6 0 4 0
3 30 0 1
3 40 0 80
3 48 0 0
7 0 0 0
1 44 80 0
3 48 0 80
7 0 0 1
1 30 1 0
3 30 0 0
3 40 0 0
7 0 0 0
5 1 F 0
6 0 4 0
3 30 0 0
7 0 0 0
1 0C 80 0
5 0 80 0
6 0 4 0
3 10 0 80
3 40 0 40
3 48 0 0
7 0 0 0
1 10 80 0
3 10 0 0
3 40 0 0
a 60 0 0
b E4 FFFFFFFF 0
a E8 0 0
3 44 0 80
3 2C 0 1
0 0 0 0

// ==== testbench/periph_tb.sv ====
`default_nettype none

`include "periph_params.svh"

module periph_tb;
	timeunit 1ns;
	timeprecision 1ns;

	import wb_pkg::*;
	import periph_pkg::*;

	// Four words per case for op, address, data and expected value
	localparam int MAX_WORDS  = 4 * 128;
	// Cycles a transfer may take before giving up
	localparam int BUS_LIMIT  = 16;
	// Upper bound for the wait operation
	localparam int WAIT_LIMIT = 64;

	// DUT inputs
	logic        wb_clk_i;
	logic        rst_n_i;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic        wb_we_i;
	wb_addr_t    wb_adr_i;
	wb_sel_t     wb_sel_i;
	wb_data_t    wb_dat_i;
	gpio0_pins_t gpio0_i;
	gpio1_pins_t gpio1_i;

	// DUT outputs
	logic        wb_ack_o;
	logic        wb_err_o;
	wb_data_t    wb_dat_o;
	gpio0_pins_t gpio0_o;
	gpio0_pins_t gpio0_oe_o;
	gpio1_pins_t gpio1_o;
	gpio1_pins_t gpio1_oe_o;
	logic        irq_o;

	logic [31:0] cases [0:MAX_WORDS-1];
	logic [31:0] lfsr_q;
	int          checks;
	int          errors;
	int          timeouts;

	periph_top u_periph_top (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_sel_i   (wb_sel_i),
		.wb_dat_i   (wb_dat_i),
		.gpio0_i    (gpio0_i),
		.gpio1_i    (gpio1_i),
		.wb_ack_o   (wb_ack_o),
		.wb_err_o   (wb_err_o),
		.wb_dat_o   (wb_dat_o),
		.gpio0_o    (gpio0_o),
		.gpio0_oe_o (gpio0_oe_o),
		.gpio1_o    (gpio1_o),
		.gpio1_oe_o (gpio1_oe_o),
		.irq_o      (irq_o)
	);

	// 100 ns period
	initial begin
		wb_clk_i = 1'b0;
		forever #50 wb_clk_i = ~wb_clk_i;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	task automatic random_word(output logic [31:0] val);
		val = '0;
		for (int i = 0; i < 32; i++) begin
			val    = {val[30:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Pin groups zero extended to a word
	function automatic logic [31:0] pin_group(input logic [31:0] sel);
		case (sel)
			32'h0:   return {24'b0, gpio0_o};
			32'h1:   return {24'b0, gpio0_oe_o};
			32'h2:   return {28'b0, gpio1_o};
			32'h3:   return {28'b0, gpio1_oe_o};
			default: return 32'hdead_beef;
		endcase
	endfunction

	// Sample on falling edges until ack or err shows up
	task automatic wait_answer(input wb_addr_t addr, output logic ack, output logic err);
		int n;
		n = 0;
		do begin
			@(negedge wb_clk_i);
			n++;
		end while (!wb_ack_o && !wb_err_o && n < BUS_LIMIT);
		ack = wb_ack_o;
		err = wb_err_o;
		if (!ack && !err) begin
			timeouts++;
			$display("Transfer at address %h got neither acknowledge nor error in %0d cycles",
				addr, BUS_LIMIT);
		end else begin
			// Answer one edge after the strobe
			check_value(n, 1, $sformatf("answer latency at %h", addr));
		end
	endtask

	task automatic wb_write(input wb_addr_t addr, input wb_data_t data,
			output logic ack, output logic err);
		@(negedge wb_clk_i);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b1;
		wb_adr_i = addr;
		wb_dat_i = data;
		wait_answer(addr, ack, err);
		// Strobe low for at least one cycle before the next transfer
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic wb_read(input wb_addr_t addr, output wb_data_t data,
			output logic ack, output logic err);
		@(negedge wb_clk_i);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b0;
		wb_adr_i = addr;
		wait_answer(addr, ack, err);
		// Address still held so the mux shows the answering slave
		data     = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Case file driven sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] expv;
		logic [31:0] got;
		logic [31:0] rnd;
		logic        ack;
		logic        err;
		int          idx;

		rst_n_i  = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		wb_adr_i = '0;
		wb_sel_i = '1;
		wb_dat_i = '0;
		gpio0_i  = '0;
		gpio1_i  = '0;
		lfsr_q   = 32'h6ee9;
		rnd      = '0;
		checks   = 0;
		errors   = 0;
		timeouts = 0;

		$readmemh("testbench/periph_cases.txt", cases);

		// Eight cycles in reset and release on a falling edge
		repeat (8) @(negedge wb_clk_i);
		rst_n_i = 1'b1;

		if ($isunknown(cases[0]) || cases[0] == 32'h0) begin
			errors++;
			$display("Case file testbench/periph_cases.txt is missing or holds no cases");
		end

		idx = 0;
		while (timeouts == 0 && idx < MAX_WORDS && !$isunknown(cases[idx])
				&& cases[idx] != 32'h0) begin
			op   = cases[idx];
			addr = cases[idx+1];
			data = cases[idx+2];
			expv = cases[idx+3];
			case (op)
				// Plain write
				32'h1: begin
					wb_write(addr, data, ack, err);
					check_value({30'b0, err, ack}, 32'h1, $sformatf("write %h answer", addr));
				end
				// Write of a fresh random word
				32'h2: begin
					random_word(rnd);
					wb_write(addr, rnd, ack, err);
					check_value({30'b0, err, ack}, 32'h1, $sformatf("write %h answer", addr));
				end
				32'h3: begin
					wb_read(addr, got, ack, err);
					check_value({30'b0, err, ack}, 32'h1, $sformatf("read %h answer", addr));
					check_value(got, expv, $sformatf("read %h data", addr));
				end
				// Expected field is the mask on the last random word
				32'h4: begin
					wb_read(addr, got, ack, err);
					check_value({30'b0, err, ack}, 32'h1, $sformatf("read %h answer", addr));
					check_value(got, rnd & expv, $sformatf("read %h data", addr));
				end
				// Address field picks the bank
				32'h5: begin
					@(negedge wb_clk_i);
					if (addr == 32'h0) begin
						gpio0_i = data[7:0];
					end else begin
						gpio1_i = data[3:0];
					end
				end
				32'h6: begin
					for (int k = 0; k < data && k < WAIT_LIMIT; k++) begin
						@(negedge wb_clk_i);
					end
				end
				32'h7: check_value({31'b0, irq_o}, expv, "irq level");
				32'h8: check_value(pin_group(addr), expv, $sformatf("pin group %0d", addr));
				32'h9: check_value(pin_group(addr), rnd & expv,
					$sformatf("pin group %0d", addr));
				// Unmapped space answers with error and zero data
				32'ha: begin
					wb_read(addr, got, ack, err);
					check_value({30'b0, err, ack}, 32'h2, $sformatf("read %h answer", addr));
					check_value(got, expv, $sformatf("read %h data", addr));
				end
				32'hb: begin
					wb_write(addr, data, ack, err);
					check_value({30'b0, err, ack}, 32'h2, $sformatf("write %h answer", addr));
				end
				default: begin
					errors++;
					$display("Case %0d has an unknown operation code %h", idx / 4, op);
				end
			endcase
			idx += 4;
		end

		$display("Cases: %0d, checks: %0d, errors: %0d, timeouts: %0d",
			idx / 4, checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
